//--- Makefile
TOP = tb_frame_export

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module frame_export_top -f frame_export_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f frame_export_top.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

//--- crc32_dibit.sv
`timescale 1ns/10ps

module crc32_dibit import eth_pkg::*; (
  input  logic   clk_in,
  input  logic   crc_clear,
  input  logic   crc_en,
  input  dibit_t crc_data,
  input  logic   crc_shift,
  output dibit_t crc_out
);

  logic [31:0] crc;

  // one bit into the reflected register
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    logic        fb;
    logic [31:0] nxt;
    fb  = c[0] ^ b;
    nxt = c >> 1;
    if (fb) begin
      nxt = nxt ^ CRC_POLY;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk_in) begin
    if (crc_clear) begin
      crc <= CRC_INIT;
    end else if (crc_en) begin
      crc <= crc_step(crc_step(crc, crc_data[0]), crc_data[1]); // bit 0 goes first
    end else if (crc_shift) begin
      crc <= {2'b00, crc[31:2]};
    end
  end

  // fcs is the complemented register, lsb first
  assign crc_out = ~crc[1:0];

endmodule

//--- eth_pkg.sv
package eth_pkg;

  typedef logic [1:0] dibit_t; // rmii txd, bit 0 first on the wire

  // count for preamble, fcs and gap, sized for the gap
  typedef logic [5:0] tx_cnt_t;

  // scanner to framer
  typedef struct packed {
    dibit_t data;
    logic   last; // final payload dibit
  } eth_stream_t;

  // ----------------------------------------
  // wire framing
  localparam int     PREAMBLE_DIBITS = 31; // preamble plus start of sfd
  localparam dibit_t PREAMBLE_DIBIT  = 2'b01;
  localparam dibit_t SFD_LAST_DIBIT  = 2'b11;
  localparam int     FCS_DIBITS      = 16;
  localparam int     IFG_DIBITS      = 48; // 12 bytes

  // ----------------------------------------
  // crc-32, reflected form
  localparam logic [31:0] CRC_POLY = 32'hEDB88320;
  localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

  typedef enum logic [2:0] {
    tx_idle,
    tx_preamble,
    tx_payload,
    tx_fcs,
    tx_gap
  } tx_state_t;

endpackage

//--- ether_export.sv
`timescale 1ns/10ps

module ether_export import img_pkg::*, eth_pkg::*; #(
  parameter int DISPLAY_WIDTH  = DEFAULT_WIDTH,
  parameter int DISPLAY_HEIGHT = DEFAULT_HEIGHT
) (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        export_trigger,
  output fb_addr_t    read_addr,
  input  pixel_t      read_data,
  output logic        tx_start,
  output eth_stream_t stream,
  input  logic        data_ready,
  input  logic        tx_ready,
  output logic        export_ready
);

  localparam int HEADER_DIBITS = HEADER_BYTES * DIBITS_PER_BYTE;
  localparam int TAG_DIBITS    = ROW_TAG_BYTES * DIBITS_PER_BYTE;
  localparam int CNT_W         = $clog2(HEADER_DIBITS);
  localparam int COL_W         = $clog2(DISPLAY_WIDTH);

  typedef enum logic [2:0] {
    exp_idle,
    exp_header,
    exp_row_start,
    exp_row_tag,
    exp_pixels
  } exp_state_t;

  exp_state_t       state;
  logic [CNT_W-1:0] cnt;      // header / tag dibits left
  row_idx_t         row;
  row_idx_t         tag_sr;   // row index, shifted out lsb first
  fb_addr_t         row_base; // row * width
  logic [COL_W-1:0] col;
  logic             parity;   // 0 upper dibit, 1 lower
  logic             last_col;
  logic             last_row;

  assign last_col = col == COL_W'(DISPLAY_WIDTH - 1);
  assign last_row = row == row_idx_t'(DISPLAY_HEIGHT - 1);

  assign export_ready = state == exp_idle && tx_ready;

  // header and rows both start on the first free framer cycle
  assign tx_start = tx_ready && (state == exp_header || state == exp_row_start);

  // ----------------------------------------
  // image walk
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= exp_idle;
      cnt      <= '0;
      row      <= '0;
      tag_sr   <= '0;
      row_base <= '0;
      col      <= '0;
      parity   <= 1'b0;
    end else begin
      case (state)
        exp_idle: begin
          if (export_ready && export_trigger) begin
            state <= exp_header;
            cnt   <= CNT_W'(HEADER_DIBITS - 1);
          end
        end
        exp_header: begin
          if (data_ready) begin
            if (cnt == 0) begin
              state    <= exp_row_start;
              row      <= '0;
              row_base <= '0;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
        end
        exp_row_start: begin
          if (tx_ready) begin
            state  <= exp_row_tag;
            cnt    <= CNT_W'(TAG_DIBITS - 1);
            tag_sr <= row;
          end
        end
        exp_row_tag: begin
          if (data_ready) begin
            tag_sr <= tag_sr >> 2;
            if (cnt == 0) begin
              state  <= exp_pixels;
              col    <= '0;
              parity <= 1'b0;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
        end
        exp_pixels: begin
          parity <= ~parity;
          if (parity) begin
            if (!last_col) begin
              col <= col + 1'b1;
            end else if (last_row) begin
              state <= exp_idle; // framer still owes fcs and gap
            end else begin
              state    <= exp_row_start;
              row      <= row + 1'b1;
              row_base <= row_base + fb_addr_t'(DISPLAY_WIDTH);
            end
          end
        end
        default: begin
          state <= exp_idle;
        end
      endcase
    end
  end

  // payload dibits and pixel prefetch
  always_comb begin
    stream    = '0;
    read_addr = row_base; // pixel 0 ready before the tag ends
    case (state)
      exp_header: begin
        stream.data = 2'b11;
        stream.last = cnt == 0;
      end
      exp_row_tag: begin
        stream.data = tag_sr[1:0];
      end
      exp_pixels: begin
        stream.data = parity ? read_data[1:0] : read_data[3:2];
        stream.last = parity && last_col;
        // on the lower dibit, fetch the next column
        read_addr   = row_base + fb_addr_t'(col) + fb_addr_t'(parity && !last_col);
      end
      default: begin
        stream = '0;
      end
    endcase
  end

  // ----------------------------------------
  a_no_pixel_gap: assert property (@(posedge clk_in) disable iff (rst_in)
    state == exp_pixels |-> data_ready);

endmodule

//--- ether_tx.sv
`timescale 1ns/10ps

module ether_tx import eth_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        tx_start,
  input  eth_stream_t stream,
  output logic        data_ready,
  output logic        tx_ready,
  output logic        eth_txen,
  output dibit_t      eth_txd
);

  tx_state_t state;
  tx_cnt_t   cnt; // shared by preamble, fcs and gap

  logic   crc_clear;
  logic   crc_en;
  logic   crc_shift;
  dibit_t crc_out;

  assign tx_ready   = state == tx_idle;
  assign data_ready = state == tx_payload; // sfd is on the wire during the first one

  assign crc_clear = tx_ready && tx_start;
  assign crc_en    = data_ready;
  assign crc_shift = state == tx_fcs && cnt != 0;

  crc32_dibit crc_inst (
    .clk_in    (clk_in),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_data  (stream.data),
    .crc_shift (crc_shift),
    .crc_out   (crc_out)
  );

  // ----------------------------------------
  // framing sequence, outputs registered
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state    <= tx_idle;
      cnt      <= '0;
      eth_txen <= 1'b0;
      eth_txd  <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (tx_start) begin
            state    <= tx_preamble;
            cnt      <= tx_cnt_t'(PREAMBLE_DIBITS - 1);
            eth_txen <= 1'b1;
            eth_txd  <= PREAMBLE_DIBIT;
          end
        end
        tx_preamble: begin
          if (cnt == 0) begin
            state   <= tx_payload;
            eth_txd <= SFD_LAST_DIBIT;
          end else begin
            cnt     <= cnt - 1'b1;
            eth_txd <= PREAMBLE_DIBIT;
          end
        end
        tx_payload: begin
          eth_txd <= stream.data; // one dibit per clock, no stalls
          if (stream.last) begin
            state <= tx_fcs;
            cnt   <= tx_cnt_t'(FCS_DIBITS);
          end
        end
        tx_fcs: begin
          // last count drops txen once the final fcs dibit is out
          if (cnt == 0) begin
            state    <= tx_gap;
            cnt      <= tx_cnt_t'(IFG_DIBITS - 1);
            eth_txen <= 1'b0;
            eth_txd  <= '0;
          end else begin
            cnt     <= cnt - 1'b1;
            eth_txd <= crc_out;
          end
        end
        tx_gap: begin
          if (cnt == 0) begin
            state <= tx_idle;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  a_last_in_payload: assert property (@(posedge clk_in) disable iff (rst_in)
    stream.last |-> data_ready);

  a_gap_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
    state == tx_gap |-> !eth_txen);

endmodule

//--- frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer import img_pkg::*; #(
  parameter int DISPLAY_WIDTH  = DEFAULT_WIDTH,
  parameter int DISPLAY_HEIGHT = DEFAULT_HEIGHT
) (
  input  logic     clk_in,
  input  fb_wr_t   fb_wr,
  input  fb_addr_t read_addr,
  output pixel_t   read_data
);

  localparam int DEPTH  = DISPLAY_WIDTH * DISPLAY_HEIGHT;
  localparam int ADDR_W = $clog2(DEPTH);

  pixel_t mem [DEPTH];

  // write side, driven from outside
  always_ff @(posedge clk_in) begin
    if (fb_wr.en) begin
      mem[fb_wr.addr[ADDR_W-1:0]] <= fb_wr.pixel;
    end
  end

  // registered read, returns old data on a same-address write
  always_ff @(posedge clk_in) begin
    read_data <= mem[read_addr[ADDR_W-1:0]];
  end

  // ----------------------------------------
  // the writer must stay inside the image
  a_wr_in_range: assert property (@(posedge clk_in)
    fb_wr.en |-> fb_wr.addr <= fb_addr_t'(DEPTH - 1));

endmodule

//--- frame_export_top.f
img_pkg.sv
eth_pkg.sv
frame_buffer.sv
crc32_dibit.sv
ether_tx.sv
ether_export.sv
frame_export_top.sv
tb_frame_export.sv

//--- frame_export_top.sv
`timescale 1ns/10ps

module frame_export_top import img_pkg::*, eth_pkg::*; #(
  parameter int DISPLAY_WIDTH  = DEFAULT_WIDTH, // even
  parameter int DISPLAY_HEIGHT = DEFAULT_HEIGHT
) (
  input  logic   clk_in,
  input  logic   rst_in,
  input  fb_wr_t fb_wr,
  input  logic   export_trigger,
  output logic   export_ready,
  output logic   eth_txen,
  output dibit_t eth_txd
);

  fb_addr_t    read_addr;
  pixel_t      read_data;
  logic        tx_start;
  eth_stream_t stream;
  logic        data_ready;
  logic        tx_ready;

  frame_buffer #(
    .DISPLAY_WIDTH  (DISPLAY_WIDTH),
    .DISPLAY_HEIGHT (DISPLAY_HEIGHT)
  ) fb_inst (
    .clk_in    (clk_in),
    .fb_wr     (fb_wr),
    .read_addr (read_addr),
    .read_data (read_data)
  );

  ether_export #(
    .DISPLAY_WIDTH  (DISPLAY_WIDTH),
    .DISPLAY_HEIGHT (DISPLAY_HEIGHT)
  ) export_inst (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .export_trigger (export_trigger),
    .read_addr      (read_addr),
    .read_data      (read_data),
    .tx_start       (tx_start),
    .stream         (stream),
    .data_ready     (data_ready),
    .tx_ready       (tx_ready),
    .export_ready   (export_ready)
  );

  ether_tx tx_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .tx_start   (tx_start),
    .stream     (stream),
    .data_ready (data_ready),
    .tx_ready   (tx_ready),
    .eth_txen   (eth_txen),
    .eth_txd    (eth_txd)
  );

endmodule

//--- img_pkg.sv
package img_pkg;

  // geometry defaults, the top level overrides them
  localparam int DEFAULT_WIDTH  = 64;
  localparam int DEFAULT_HEIGHT = 48;

  typedef logic [3:0]  pixel_t;   // 4-bit grayscale
  typedef logic [15:0] fb_addr_t; // max supported depth
  typedef logic [31:0] row_idx_t; // sent at the head of each row frame

  // ----------------------------------------
  // frame buffer write port
  typedef struct packed {
    logic     en;
    fb_addr_t addr;  // row * width + column
    pixel_t   pixel;
  } fb_wr_t;

  // ----------------------------------------
  // export framing
  localparam int HEADER_BYTES    = 50; // all ones
  localparam int ROW_TAG_BYTES   = 4;  // little endian row index
  localparam int DIBITS_PER_BYTE = 4;

endpackage

//--- tb_frame_export.sv
`timescale 1ns/10ps

module tb_frame_export import img_pkg::*, eth_pkg::*; ();

  localparam int W       = 8;
  localparam int H       = 4;
  localparam int DEPTH   = W * H;
  // tx_start to tx_ready outside the payload
  localparam int FIX_CYC = 1 + PREAMBLE_DIBITS + 1 + FCS_DIBITS + IFG_DIBITS;
  localparam int HDR_CYC = FIX_CYC + DIBITS_PER_BYTE * HEADER_BYTES;
  localparam int ROW_CYC = FIX_CYC + DIBITS_PER_BYTE * (ROW_TAG_BYTES + W / 2);
  localparam int MAX_CYC = 2 * 2 * (HDR_CYC + H * ROW_CYC) + DEPTH + W + 2 * IFG_DIBITS;

  logic   clk_in;
  logic   rst_in;
  fb_wr_t fb_wr;
  logic   export_trigger;
  logic   export_ready;
  logic   eth_txen;
  dibit_t eth_txd;

  pixel_t img [DEPTH]; // model of the frame buffer
  dibit_t run_q[$];    // frame on the wire
  dibit_t cap[$];      // last complete frame
  dibit_t exp_q[$];    // expected payload dibits
  int     mon_errors = 0;
  int     frame_errors = 0;
  int     run_errors = 0;
  int     frames_seen = 0;
  int     exports = 0;
  int     low_run = 0; // txen low cycles since the last frame
  int     cycles = 0;
  logic   txen_d;
  logic   ready_d;
  event   frame_done;

  frame_export_top #(
    .DISPLAY_WIDTH  (W),
    .DISPLAY_HEIGHT (H)
  ) UUT (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .fb_wr          (fb_wr),
    .export_trigger (export_trigger),
    .export_ready   (export_ready),
    .eth_txen       (eth_txen),
    .eth_txd        (eth_txd)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  // ----------------------------------------
  // reference model
  function automatic void expected_payload(input int idx);
    row_idx_t   r;
    pixel_t     px;
    logic [7:0] b;
    exp_q.delete();
    r = row_idx_t'(idx - 1);
    for (int i = 0; i < (idx == 0 ? HEADER_BYTES : ROW_TAG_BYTES); i++) begin
      b = (idx == 0) ? 8'hFF : r[8*i +: 8]; // row index little endian
      for (int k = 0; k < 4; k++) begin
        exp_q.push_back(b[2*k +: 2]);
      end
    end
    for (int c = 0; idx != 0 && c < W; c++) begin
      px = img[(idx - 1) * W + c];
      exp_q.push_back(px[3:2]); // upper dibit first
      exp_q.push_back(px[1:0]);
    end
  endfunction

  // bitwise crc-32, bit 0 of each dibit first
  function automatic logic [31:0] crc32_ref(input dibit_t d[$]);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    foreach (d[i]) begin
      for (int k = 0; k < 2; k++) begin
        if (c[0] ^ d[i][k]) begin
          c = (c >> 1) ^ 32'hEDB88320;
        end else begin
          c = c >> 1;
        end
      end
    end
    return ~c;
  endfunction

  task automatic check_frame(input int fno);
    logic [31:0] fcs;
    dibit_t      want;
    int          plen;
    expected_payload(fno % (H + 1));
    plen = exp_q.size();
    fcs  = crc32_ref(exp_q);
    assert (cap.size() == 32 + plen + FCS_DIBITS) else begin
      frame_errors++;
      $display("Mismatch eth_txen frame %0d length: got %h expected %h",
               fno, cap.size(), 32 + plen + FCS_DIBITS);
    end
    for (int i = 0; i < cap.size() && i < 32 + plen + FCS_DIBITS; i++) begin
      if (i < PREAMBLE_DIBITS) begin
        want = 2'b01;
      end else if (i == PREAMBLE_DIBITS) begin
        want = 2'b11; // end of sfd
      end else if (i < 32 + plen) begin
        want = exp_q[i - 32];
      end else begin
        want = fcs[2 * (i - 32 - plen) +: 2];
      end
      assert (cap[i] === want) else begin
        frame_errors++;
        $display("Mismatch eth_txd frame %0d dibit %0d: got %h expected %h",
                 fno, i, cap[i], want);
      end
    end
  endtask

  // ----------------------------------------
  // capture txen runs as frames
  always @(negedge clk_in) begin
    if (rst_in !== 1'b0) begin
      txen_d  = 1'b0;
      ready_d = export_ready;
    end else begin
      if (eth_txen) begin
        if (!txen_d && frames_seen > 0) begin
          assert (low_run >= IFG_DIBITS) else begin
            mon_errors++;
            $display("interframe gap of %0d cycles is too short", low_run);
          end
        end
        assert (!export_ready) else begin
          mon_errors++;
          $display("export_ready high while a frame is on the wire");
        end
        run_q.push_back(eth_txd);
        low_run = 0;
      end else begin
        low_run++;
        if (txen_d) begin
          cap = run_q;
          run_q.delete();
          frames_seen++;
          ->frame_done;
        end
      end
      if (ready_d && !export_ready) begin
        exports++;
      end
      if (!ready_d && export_ready) begin
        assert (frames_seen == exports * (H + 1) && low_run >= IFG_DIBITS) else begin
          mon_errors++;
          $display("export_ready returned early, %0d frames and gap %0d", frames_seen, low_run);
        end
      end
      txen_d  = eth_txen;
      ready_d = export_ready;
    end
  end

  initial begin
    forever begin
      @(frame_done);
      check_frame(frames_seen - 1);
    end
  end

  initial begin
    while (cycles < MAX_CYC) begin
      @(posedge clk_in);
      cycles++;
    end
    $display("timeout, export not finished after %0d cycles", MAX_CYC);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------
  // stimulus
  task automatic write_pixels(input int first, input int count, input logic change);
    pixel_t px;
    for (int a = first; a < first + count; a++) begin
      px = change ? img[a] ^ pixel_t'(1 + $urandom_range(14)) : pixel_t'($urandom);
      img[a] = px;
      fb_wr  = '{en: 1'b1, addr: fb_addr_t'(a), pixel: px};
      @(negedge clk_in);
    end
    fb_wr = '0;
  endtask

  task automatic run_export(input logic hold);
    while (!export_ready) begin
      @(negedge clk_in);
    end
    export_trigger = 1'b1;
    if (!hold) begin
      @(negedge clk_in);
      export_trigger = 1'b0;
    end
    while (export_ready) begin
      @(negedge clk_in);
    end
    while (!export_ready) begin
      @(negedge clk_in);
    end
    export_trigger = 1'b0; // dropped before the next sample
  endtask

  initial begin
    rst_in         = 1'b1;
    fb_wr          = '0;
    export_trigger = 1'b0;
    void'($urandom(32'h45d3));
    repeat (2) @(negedge clk_in);
    rst_in = 1'b0;
    assert (export_ready === 1'b1 && eth_txen === 1'b0) else begin
      run_errors++;
      $display("export_ready low or eth_txen high after reset");
    end
    write_pixels(0, DEPTH, 1'b0);
    run_export(1'b0);
    write_pixels(W, W + 3, 1'b1); // row 1 and the start of row 2
    run_export(1'b1);             // trigger held through the export
    repeat (2 * IFG_DIBITS) @(negedge clk_in);
    assert (exports == 2 && frames_seen == 2 * (H + 1) && export_ready) else begin
      run_errors++;
      $display("expected 2 exports, saw %0d exports and %0d frames", exports, frames_seen);
    end
    $display("errors: monitor %0d, frames %0d, sequence %0d",
             mon_errors, frame_errors, run_errors);
    if (mon_errors + frame_errors + run_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
